/* include/cdc_macros.svh */
`ifndef CDC_MACROS_SVH
`define CDC_MACROS_SVH

// Number of independent event channels.
`define NUM_EVENTS 4

// Flops in each level synchronizer.
`define SYNC_STAGES 3

// Backlog counter width, so a channel holds up to 2**w-1 pending events.
`define BACKLOG_WIDTH 4

// Destination counter width, counters wrap at 2**w.
`define COUNT_WIDTH 16

`endif

/* design/cdc_pkg.sv */
`default_nettype none

`include "cdc_macros.svh"

package cdc_pkg;

	// One bit per channel for pulses, busy levels and overflow flags.
	typedef logic [`NUM_EVENTS-1:0] event_vec_t;

	// Pending events held on the input side of one channel.
	typedef logic [`BACKLOG_WIDTH-1:0] backlog_t;

	// Events counted on the output side of one channel.
	typedef logic [`COUNT_WIDTH-1:0] count_t;

	// All channel counts, channel 0 in the low slice.
	typedef count_t [`NUM_EVENTS-1:0] count_arr_t;

	// Backlog is full at all ones.
	localparam backlog_t BACKLOG_MAX = '1;

endpackage

`default_nettype wire

/* design/bit_synchronizer.sv */
`default_nettype none

`include "cdc_macros.svh"

module bit_synchronizer (
	input  wire logic clk,    // Destination clock.
	input  wire logic arst_n, // Async reset, active low.
	input  wire logic din,    // Level from the foreign domain.
	output logic      dout    // Level safe to use in clk.
);

	logic [`SYNC_STAGES-1:0] sync_q; // Stage 0 may go metastable.

	// Shift the level along the chain, one stage per destination edge.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= '0; // Chain idles low.
		end else begin
			sync_q <= {sync_q[`SYNC_STAGES-2:0], din}; // New sample enters at bit 0.
		end
	end

	assign dout = sync_q[`SYNC_STAGES-1]; // Last stage is settled.

endmodule

`default_nettype wire

/* design/pulse_synchronizer.sv */
`default_nettype none

module pulse_synchronizer (
	input  wire logic clk_a,   // Source clock.
	input  wire logic clk_b,   // Destination clock.
	input  wire logic arst_n,  // Async reset for both domains.
	input  wire logic issue_a, // Single-cycle strobe in clk_a.
	output logic      pulse_b, // Single-cycle strobe in clk_b.
	output logic      busy_a   // Toggle still in flight.
);

	logic tx_a;   // Transmit toggle.
	logic rx_b;   // Toggle after crossing into clk_b.
	logic rx_b_q; // Delayed copy for edge detection.
	logic ack_a;  // Toggle returned into clk_a.

	// Each issue flips the transmit level.
	always_ff @(posedge clk_a or negedge arst_n) begin
		if (!arst_n) begin
			tx_a <= 1'b0;
		end else if (issue_a) begin
			tx_a <= ~tx_a; // One flip per event.
		end
	end

	bit_synchronizer u_sync_fwd (.clk(clk_b), .arst_n(arst_n), .din(tx_a), .dout(rx_b));

	// Any change of the crossed toggle is one event.
	always_ff @(posedge clk_b or negedge arst_n) begin
		if (!arst_n) begin
			rx_b_q  <= 1'b0;
			pulse_b <= 1'b0;
		end else begin
			rx_b_q  <= rx_b;
			pulse_b <= (rx_b != rx_b_q); // High for one clk_b cycle.
		end
	end

	// Send back the level the edge detector has already taken.
	bit_synchronizer u_sync_ret (.clk(clk_a), .arst_n(arst_n), .din(rx_b_q), .dout(ack_a));

	assign busy_a = tx_a ^ ack_a; // Low once the round trip completes.

endmodule

`default_nettype wire

/* design/event_capture.sv */
`default_nettype none

`include "cdc_macros.svh"

module event_capture (
	input  wire logic                clk_a,      // Source clock.
	input  wire logic                arst_n,     // Async reset, active low.
	input  wire cdc_pkg::event_vec_t event_a,    // Event strobes.
	input  wire cdc_pkg::event_vec_t busy_a,     // Synchronizer busy levels.
	output cdc_pkg::event_vec_t      issue_a,    // Registered issue strobes.
	output cdc_pkg::event_vec_t      overflow_a  // Sticky drop flags.
);

	import cdc_pkg::*;

	backlog_t   backlog_q [`NUM_EVENTS]; // Pending events per channel.
	event_vec_t pending;                 // Backlog is nonzero.
	event_vec_t full;                    // Backlog at its maximum.
	event_vec_t drop;                    // Event lost this cycle.
	event_vec_t issue_d;                 // Next issue strobes.

	// Per-channel status decoded from the backlog.
	always_comb begin
		for (int i = 0; i < `NUM_EVENTS; i++) begin
			pending[i] = (backlog_q[i] != '0);
			full[i]    = (backlog_q[i] == BACKLOG_MAX);
			// An issue in the same cycle frees room, so nothing is lost then.
			drop[i]    = event_a[i] && full[i] && !issue_a[i];
		end
	end

	// Issue only into an idle synchronizer.
	// The strobe in flight blocks a second one, since busy rises a cycle late.
	assign issue_d = pending & ~busy_a & ~issue_a;

	always_ff @(posedge clk_a or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `NUM_EVENTS; i++) begin
				backlog_q[i] <= '0;
			end
			issue_a    <= '0;
			overflow_a <= '0;
		end else begin
			for (int i = 0; i < `NUM_EVENTS; i++) begin
				if (event_a[i] && !issue_a[i] && !full[i]) begin
					backlog_q[i] <= backlog_q[i] + 1'b1; // Take the event.
				end else if (issue_a[i] && !event_a[i]) begin
					backlog_q[i] <= backlog_q[i] - 1'b1; // One event left.
				end
				// Event plus issue leaves the count as it was.
			end
			issue_a    <= issue_d;
			overflow_a <= overflow_a | drop; // Cleared by reset only.
		end
	end

endmodule

`default_nettype wire

/* design/event_counter.sv */
`default_nettype none

`include "cdc_macros.svh"

module event_counter (
	input  wire logic                clk_b,   // Destination clock.
	input  wire logic                arst_n,  // Async reset, active low.
	input  wire logic                clear_b, // Synchronous clear of all counts.
	input  wire cdc_pkg::event_vec_t pulse_b, // Event strobes from the crossing.
	output cdc_pkg::count_arr_t      count_b  // Wrapping per-channel counts.
);

	import cdc_pkg::*;

	count_arr_t count_q; // Count registers.
	count_arr_t count_d; // Next counts.

	// Clear wins over a pulse arriving in the same cycle.
	always_comb begin
		for (int i = 0; i < `NUM_EVENTS; i++) begin
			if (clear_b) begin
				count_d[i] = '0;
			end else if (pulse_b[i]) begin
				count_d[i] = count_q[i] + 1'b1; // Wraps at the top.
			end else begin
				count_d[i] = count_q[i];
			end
		end
	end

	always_ff @(posedge clk_b or negedge arst_n) begin
		if (!arst_n) begin
			count_q <= '0;
		end else begin
			count_q <= count_d;
		end
	end

	assign count_b = count_q; // Counts seen a cycle after each pulse.

endmodule

`default_nettype wire

/* design/cdc_event_bridge.sv */
`default_nettype none

`include "cdc_macros.svh"

module cdc_event_bridge (
	input  wire logic                clk_a,      // Event domain clock.
	input  wire logic                clk_b,      // Counting domain clock.
	input  wire logic                arst_n,     // Async reset for both domains.
	input  wire cdc_pkg::event_vec_t event_a,    // Event strobes in clk_a.
	input  wire logic                clear_b,    // Count clear in clk_b.
	output cdc_pkg::event_vec_t      overflow_a, // Sticky backlog overflow.
	output cdc_pkg::count_arr_t      count_b     // Event counts in clk_b.
);

	import cdc_pkg::*;

	event_vec_t issue_a; // Strobes into the crossings.
	event_vec_t busy_a;  // Crossing still in flight.
	event_vec_t pulse_b; // Strobes out of the crossings.

	// Input side holds events until the crossing is free.
	event_capture u_capture (
		.clk_a      (clk_a),
		.arst_n     (arst_n),
		.event_a    (event_a),
		.busy_a     (busy_a),
		.issue_a    (issue_a),
		.overflow_a (overflow_a)
	);

	// One handshaked toggle crossing per channel.
	for (genvar i = 0; i < `NUM_EVENTS; i++) begin : g_sync
		pulse_synchronizer u_pulse_sync (
			.clk_a   (clk_a),
			.clk_b   (clk_b),
			.arst_n  (arst_n),
			.issue_a (issue_a[i]),
			.pulse_b (pulse_b[i]),
			.busy_a  (busy_a[i])
		);
	end

	event_counter u_counter (
		.clk_b   (clk_b),
		.arst_n  (arst_n),
		.clear_b (clear_b),
		.pulse_b (pulse_b),
		.count_b (count_b)
	);

endmodule

`default_nettype wire

/* tests/cdc_event_properties.sv */
`default_nettype none

`include "cdc_macros.svh"

module cdc_event_properties #(
	parameter int N        = 1,   // Channels seen by this instance.
	parameter bit CROSSING = 1'b1 // Bound into a crossing, else into the capture side.
) (
	input wire logic         clk_a,   // Source clock.
	input wire logic         clk_b,   // Destination clock.
	input wire logic         arst_n,  // Async reset, active low.
	input wire logic [N-1:0] issue_a, // Issue strobes.
	input wire logic [N-1:0] busy_a,  // Crossing busy levels.
	input wire logic [N-1:0] pulse_b, // Strobes out of the crossing.
	input wire logic [N-1:0] event_a, // Incoming event strobes.
	input wire logic [N-1:0] full_a   // Backlog at its maximum.
);

	if (CROSSING) begin : g_crossing
		// A crossed event lasts one clk_b cycle only.
		a_pulse_single : assert property (@(posedge clk_b) disable iff (!arst_n)
			(pulse_b & $past(pulse_b)) == '0)
			else $error("pulse_b was high in two consecutive clk_b cycles");

		// No second toggle while the first is still on its way.
		a_issue_idle : assert property (@(posedge clk_a) disable iff (!arst_n)
			(issue_a & busy_a) == '0)
			else $error("issue_a was raised while busy_a was high");
	end else begin : g_capture
		for (genvar i = 0; i < N; i++) begin : g_backlog
			// Full backlog drops the event instead of wrapping.
			a_backlog_cap : assert property (@(posedge clk_a) disable iff (!arst_n)
				full_a[i] && event_a[i] && !issue_a[i] |=> full_a[i])
				else $error("backlog of channel %0d went past its maximum", i);
		end
	end

endmodule

bind pulse_synchronizer cdc_event_properties #(.N(1), .CROSSING(1'b1)) u_props (
	.clk_a   (clk_a),
	.clk_b   (clk_b),
	.arst_n  (arst_n),
	.issue_a (issue_a),
	.busy_a  (busy_a),
	.pulse_b (pulse_b),
	.event_a (1'b0),
	.full_a  (1'b0)
);

bind event_capture cdc_event_properties #(.N(`NUM_EVENTS), .CROSSING(1'b0)) u_props (
	.clk_a   (clk_a),
	.clk_b   (clk_a),
	.arst_n  (arst_n),
	.issue_a (issue_a),
	.busy_a  (busy_a),
	.pulse_b ('0),
	.event_a (event_a),
	.full_a  (full)
);

`default_nettype wire

/* tests/cdc_event_checker.sv */
`default_nettype none

`include "cdc_macros.svh"

module cdc_event_checker (
	input  wire logic                clk_a,       // Event domain clock.
	input  wire logic                clk_b,       // Counting domain clock.
	input  wire logic                arst_n,      // Async reset, active low.
	input  wire cdc_pkg::event_vec_t event_a,     // Events sent into the DUT.
	input  wire logic                clear_b,     // Count clear seen by the DUT.
	input  wire cdc_pkg::event_vec_t overflow_a,  // DUT overflow flags.
	input  wire cdc_pkg::count_arr_t count_b,     // DUT counts.
	input  wire logic                check_req,   // Compare now.
	input  var  int                  check_id,    // Test number.
	input  var  int                  check_chan,  // Channel hit by an overflow burst.
	input  var  int                  check_burst, // Burst length, zero for exact tests.
	output int                       pass_count,  // Tests without error.
	output int                       fail_count   // Tests with an error.
);

	import cdc_pkg::*;

	localparam int BACKLOG_DEPTH = (1 << `BACKLOG_WIDTH) - 1; // Events a backlog can hold.

	int         sent_total [`NUM_EVENTS]; // Events sent since reset.
	int         sent_base  [`NUM_EVENTS]; // Totals at the last clear.
	event_vec_t ovf_exp;                  // Overflow bits that must be set.

	// Expected count is the events sent since the last clear, wrapped to the counter width.
	function automatic count_t expected_count(input int total, input int base);
		return count_t'(total - base);
	endfunction

	function automatic string test_name(input int id);
		case (id)
			1: return "reset";
			2: return "single_events";
			3: return "burst_no_loss";
			4: return "random_all_channels";
			5: return "burst_overflow";
			6: return "clear";
			7: return "count_after_clear";
			default: return "unknown";
		endcase
	endfunction

	task automatic run_check();
		string  name;
		logic   bad;
		count_t exp;
		int     act;
		int     lo;
		name = test_name(check_id);
		bad  = 1'b0;
		if (check_burst > 0) begin
			ovf_exp = ovf_exp | (event_vec_t'(1) << check_chan); // Sticky from now on.
		end
		for (int ch = 0; ch < `NUM_EVENTS; ch++) begin
			exp = expected_count(sent_total[ch], sent_base[ch]);
			act = int'(count_b[ch]);
			if (check_burst > 0 && ch == check_chan) begin
				lo = int'(exp) - (check_burst - BACKLOG_DEPTH); // Most that may be dropped.
				if (act < lo || act > int'(exp)) begin
					$display("mismatch %s ch%0d: expected %0d to %0d actual %0d",
						name, ch, lo, int'(exp), act);
					bad = 1'b1;
				end
			end else if (count_b[ch] !== exp) begin
				$display("mismatch %s ch%0d: expected %0d actual %0d", name, ch, exp, count_b[ch]);
				bad = 1'b1;
			end
		end
		if (overflow_a !== ovf_exp) begin
			$display("mismatch %s overflow_a: expected %b actual %b", name, ovf_exp, overflow_a);
			bad = 1'b1;
		end
		if (bad) begin
			fail_count++;
		end else begin
			pass_count++;
		end
		$display("test %0d %s: %s", check_id, name, bad ? "FAIL" : "ok");
	endtask

	// Count every strobe the DUT takes in.
	always @(posedge clk_a) begin
		for (int i = 0; i < `NUM_EVENTS; i++) begin
			if (!arst_n) begin
				sent_total[i] <= 0;
			end else if (event_a[i]) begin
				sent_total[i] <= sent_total[i] + 1;
			end
		end
	end

	// Track clears and compare on request.
	always @(posedge clk_b) begin
		if (!arst_n) begin
			ovf_exp = '0;
			for (int i = 0; i < `NUM_EVENTS; i++) begin
				sent_base[i] = 0;
			end
		end else begin
			if (clear_b) begin
				for (int i = 0; i < `NUM_EVENTS; i++) begin
					sent_base[i] = sent_total[i]; // Counting restarts here.
				end
			end
			if (check_req) begin
				run_check();
			end
		end
	end

endmodule

`default_nettype wire

/* tests/tb_cdc_event_bridge.sv */
`default_nettype none

`include "cdc_macros.svh"

module tb_cdc_event_bridge;

	import cdc_pkg::*;

	localparam int CLK_A_HALF   = 10;                   // clk_a period 20.
	localparam int CLK_B_HALF   = 17;                   // clk_b period 34.
	localparam int SETTLE_B     = 2 * `SYNC_STAGES + 4; // Extra clk_b cycles before a check.
	localparam int BURST_LEN    = 15;                   // Fits the backlog.
	localparam int OVF_BURST    = 40;                   // Overruns the backlog.
	localparam int RAND_ROUNDS  = 30;
	localparam int RAND_CAP     = 12;                   // Events per channel in the random test.
	localparam int NUM_CHECKS   = 7;
	localparam int BURST_CH     = 1 % `NUM_EVENTS;
	localparam int OVF_CH       = 2 % `NUM_EVENTS;
	localparam int TEST_EVENTS  = `NUM_EVENTS + BURST_LEN + RAND_ROUNDS * `NUM_EVENTS
		+ OVF_BURST + 7 * `NUM_EVENTS;
	localparam int WATCHDOG_TIME = 16 * 2 * CLK_A_HALF
		+ (TEST_EVENTS + NUM_CHECKS) * SETTLE_B * 3 * 2 * CLK_B_HALF;

	logic        clk_a;
	logic        clk_b;
	logic        arst_n;
	event_vec_t  event_a;
	logic        clear_b;
	event_vec_t  overflow_a;
	count_arr_t  count_b;
	logic        check_req;
	int          check_id;
	int          check_chan;
	int          check_burst;
	int          pass_count;
	int          fail_count;
	logic [31:0] lfsr_state; // Shared random state.

	always #CLK_A_HALF clk_a = ~clk_a;
	always #CLK_B_HALF clk_b = ~clk_b;

	cdc_event_bridge u_dut (
		.clk_a      (clk_a),
		.clk_b      (clk_b),
		.arst_n     (arst_n),
		.event_a    (event_a),
		.clear_b    (clear_b),
		.overflow_a (overflow_a),
		.count_b    (count_b)
	);

	cdc_event_checker u_checker (
		.clk_a       (clk_a),
		.clk_b       (clk_b),
		.arst_n      (arst_n),
		.event_a     (event_a),
		.clear_b     (clear_b),
		.overflow_a  (overflow_a),
		.count_b     (count_b),
		.check_req   (check_req),
		.check_id    (check_id),
		.check_chan  (check_chan),
		.check_burst (check_burst),
		.pass_count  (pass_count),
		.fail_count  (fail_count)
	);

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw(input int n, output int value);
		value = 0;
		repeat (n) begin
			value = (value << 1) | int'(lfsr_state[0]); // One step per bit.
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// Nothing pending, issued or in flight on any channel.
	function automatic logic idle_now();
		return (u_dut.busy_a == '0) && (u_dut.issue_a == '0) && (u_dut.u_capture.pending == '0);
	endfunction

	task automatic pulse_events(input event_vec_t mask, input int n);
		repeat (n) begin
			@(posedge clk_a);
			#2;
			event_a = mask; // One strobe per clk_a cycle.
		end
		@(posedge clk_a);
		#2;
		event_a = '0;
	endtask

	task automatic wait_settled();
		do begin
			@(negedge clk_a); // Domain A is stable here.
		end while (!idle_now());
		repeat (SETTLE_B) @(posedge clk_b);
	endtask

	task automatic request_check(input int id, input int chan, input int burst);
		wait_settled();
		@(posedge clk_b);
		#2;
		check_id    = id;
		check_chan  = chan;
		check_burst = burst;
		check_req   = 1'b1;
		@(posedge clk_b);
		#2;
		check_req   = 1'b0;
	endtask

	task automatic clear_counts();
		@(posedge clk_b);
		#2;
		clear_b = 1'b1; // Held for one clk_b cycle.
		@(posedge clk_b);
		#2;
		clear_b = 1'b0;
	endtask

	task automatic random_events(input int rounds);
		int         sent [`NUM_EVENTS];
		int         bits;
		int         gap;
		event_vec_t mask;
		for (int ch = 0; ch < `NUM_EVENTS; ch++) begin
			sent[ch] = 0;
		end
		repeat (rounds) begin
			draw(`NUM_EVENTS, bits);
			mask = '0;
			for (int ch = 0; ch < `NUM_EVENTS; ch++) begin
				if (bits[ch] && sent[ch] < RAND_CAP) begin // Cap keeps backlogs short of full.
					mask[ch] = 1'b1;
					sent[ch]++;
				end
			end
			pulse_events(mask, 1);
			draw(3, gap);
			repeat (gap) @(posedge clk_a);
		end
	endtask

	initial begin
		clk_a       = 1'b0;
		clk_b       = 1'b0;
		arst_n      = 1'b0;
		event_a     = '0;
		clear_b     = 1'b0;
		check_req   = 1'b0;
		check_id    = 0;
		check_chan  = 0;
		check_burst = 0;
		lfsr_state  = 32'hd713;
		repeat (16) @(posedge clk_a);
		#2;
		arst_n = 1'b1;
		request_check(1, 0, 0);
		for (int ch = 0; ch < `NUM_EVENTS; ch++) begin
			pulse_events(event_vec_t'(1) << ch, 1);
			wait_settled(); // Wide spacing.
		end
		request_check(2, 0, 0);
		pulse_events(event_vec_t'(1) << BURST_CH, BURST_LEN);
		request_check(3, 0, 0);
		random_events(RAND_ROUNDS);
		request_check(4, 0, 0);
		pulse_events(event_vec_t'(1) << OVF_CH, OVF_BURST);
		request_check(5, OVF_CH, OVF_BURST);
		clear_counts();
		request_check(6, 0, 0);
		pulse_events('1, 6);
		pulse_events(event_vec_t'(1), 3);
		request_check(7, 0, 0);
		repeat (4) @(posedge clk_b);
		$display("checks: %0d ok, %0d with errors", pass_count, fail_count);
		if (fail_count == 0 && pass_count == NUM_CHECKS) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Watchdog bounds the whole run.
	initial begin
		#(WATCHDOG_TIME);
		$display("timeout: the tests did not finish in the allowed time");
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
design/cdc_pkg.sv
design/bit_synchronizer.sv
design/pulse_synchronizer.sv
design/event_capture.sv
design/event_counter.sv
design/cdc_event_bridge.sv
tests/cdc_event_properties.sv
tests/cdc_event_checker.sv
tests/tb_cdc_event_bridge.sv

/* run.sh */
#!/bin/sh
# Build and run the event bridge testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_cdc_event_bridge

verilator --binary --timing --assert -f compile.f --top-module "$TOP" -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
	echo "Simulation log holds no result line"
	exit 1
fi
exit 0
